//--- verilog.f
common/uart_cmd_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
src/cmd_assembler.sv
src/cmd_exec.sv
src/cmd_uart_top.sv
dv/tb_cmd_uart.sv

//--- dv/tb_cmd_uart.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the serial command port.
// Serial driver and monitor, register reference model, response
// checker, directed and random tests, cycle timeout and summary.
//////////////////////////////////////////////////////////////////////
module tb_cmd_uart;

  localparam int DRIVE_DLY      = 1;  // Input change after the rising edge.
  localparam int TIMEOUT_CYCLES = 40 * 30 * uart_cmd_pkg::BAUD_DIV * 3 / 2;

  logic                clk;
  logic                rst_n;
  logic                rx;                        // Serial line into the DUT.
  logic                tx;                        // Serial line from the DUT.
  uart_cmd_pkg::byte_t model_regs [16];           // Reference register bank.
  uart_cmd_pkg::byte_t exp_q [$];                 // Responses still expected.
  int                  rsp_cnt;                   // Responses received.
  int                  err_cnt;                   // All errors so far.
  int                  test_cnt;                  // Tests finished.
  int                  fail_cnt;                  // Tests with errors.
  int                  test_err_base;             // err_cnt when a test began.
  string               test_name;
  int                  cyc_cnt;                   // Cycles since time zero.
  int                  seed;

  cmd_uart_top i_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .tx    (tx)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // Period 40.
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////
  function automatic uart_cmd_pkg::byte_t ref_exec(input uart_cmd_pkg::cmd_t c);
    uart_cmd_pkg::opcode_t   op;
    uart_cmd_pkg::reg_addr_t a;
    uart_cmd_pkg::byte_t     d;
    uart_cmd_pkg::byte_t     r;
    op = c[15:12];
    a  = c[11:8];
    d  = c[7:0];
    case (op)
      uart_cmd_pkg::OP_WRITE: begin
        model_regs[a] = d;
        r = uart_cmd_pkg::RESP_ACK;
      end
      uart_cmd_pkg::OP_READ: r = model_regs[a];
      uart_cmd_pkg::OP_ADD: begin
        model_regs[a] = model_regs[a] + d;  // Wraps at 8 bits.
        r = model_regs[a];
      end
      uart_cmd_pkg::OP_XOR: begin
        model_regs[a] = model_regs[a] ^ d;
        r = model_regs[a];
      end
      default: r = uart_cmd_pkg::RESP_NAK;  // Bank untouched.
    endcase
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Serial driver and monitor
  //////////////////////////////////////////////////////////////////////
  task automatic send_byte(input uart_cmd_pkg::byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};  // Stop, data, start. LSB goes first.
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #DRIVE_DLY;
      rx = frame[i];
      repeat (uart_cmd_pkg::BAUD_DIV - 1) @(posedge clk);
    end
  endtask

  task automatic recv_byte(output uart_cmd_pkg::byte_t b);
    do @(negedge clk); while (tx !== 1'b0);           // Start edge.
    repeat (uart_cmd_pkg::BAUD_DIV / 2) @(negedge clk);  // Middle of start bit.
    if (tx !== 1'b0) begin
      $display("ERROR: start bit on tx did not last to mid-bit");
      err_cnt++;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (uart_cmd_pkg::BAUD_DIV) @(negedge clk);
      b[i] = tx;
    end
    repeat (uart_cmd_pkg::BAUD_DIV) @(negedge clk);
    if (tx !== 1'b1) begin
      $display("ERROR: stop bit on tx was not high");
      err_cnt++;
    end
  endtask

  // Compares every response on tx with the oldest expected value.
  initial begin
    uart_cmd_pkg::byte_t got;
    uart_cmd_pkg::byte_t exp;
    @(posedge rst_n);
    forever begin
      recv_byte(got);
      if (exp_q.size() == 0) begin
        $display("ERROR: response 0x%h arrived with no command pending", got);
        err_cnt++;
      end else begin
        exp = exp_q.pop_front();
        if (got !== exp) begin
          $display("MISMATCH resp expected 0x%h actual 0x%h", exp, got);
          err_cnt++;
        end
      end
      rsp_cnt++;
    end
  end

  // Sends one command and waits for its response.
  task automatic run_cmd(input uart_cmd_pkg::opcode_t op, input uart_cmd_pkg::reg_addr_t addr,
                         input uart_cmd_pkg::byte_t data);
    uart_cmd_pkg::cmd_t c;
    int                 target;
    c      = {op, addr, data};
    target = rsp_cnt + 1;
    exp_q.push_back(ref_exec(c));
    send_byte(c[15:8]);  // High byte first.
    send_byte(c[7:0]);
    while (rsp_cnt < target) @(negedge clk);
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = err_cnt;
  endtask

  task automatic close_test;
    test_cnt++;
    if (err_cnt == test_err_base) begin
      $display("test %0d %s: ok", test_cnt, test_name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: failed with %0d errors", test_cnt, test_name,
               err_cnt - test_err_base);
    end
  endtask

  // Ends a run that stalls, for instance on a response that never comes.
  initial begin
    cyc_cnt = 0;
    while (cyc_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cyc_cnt++;
    end
    $display("ERROR: timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] r;
    rst_n    = 1'b0;
    rx       = 1'b1;  // Line idles high.
    rsp_cnt  = 0;
    err_cnt  = 0;
    test_cnt = 0;
    fail_cnt = 0;
    seed     = 32'h9bda356d;
    for (int i = 0; i < 16; i++)
      model_regs[i] = '0;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    start_test("reset state");
    for (int i = 0; i < 100; i++) begin
      @(negedge clk);
      if (tx !== 1'b1) begin
        $display("ERROR: tx left the idle level %0d cycles after reset", i);
        err_cnt++;
      end
    end
    run_cmd(uart_cmd_pkg::OP_READ, 4'd0, 8'h00);
    run_cmd(uart_cmd_pkg::OP_READ, 4'd5, 8'h00);
    run_cmd(uart_cmd_pkg::OP_READ, 4'd10, 8'h00);
    run_cmd(uart_cmd_pkg::OP_READ, 4'd15, 8'h00);
    close_test();

    start_test("write and read back");
    run_cmd(uart_cmd_pkg::OP_WRITE, 4'd0, 8'h3C);
    run_cmd(uart_cmd_pkg::OP_WRITE, 4'd7, 8'h81);
    run_cmd(uart_cmd_pkg::OP_WRITE, 4'd15, 8'hFF);
    run_cmd(uart_cmd_pkg::OP_READ, 4'd0, 8'h00);
    run_cmd(uart_cmd_pkg::OP_READ, 4'd7, 8'h00);
    run_cmd(uart_cmd_pkg::OP_READ, 4'd15, 8'h00);
    close_test();

    start_test("arithmetic");
    run_cmd(uart_cmd_pkg::OP_WRITE, 4'd3, 8'hF0);
    run_cmd(uart_cmd_pkg::OP_ADD, 4'd3, 8'h20);    // Wraps to 0x10.
    run_cmd(uart_cmd_pkg::OP_WRITE, 4'd5, 8'h5A);
    run_cmd(uart_cmd_pkg::OP_XOR, 4'd5, 8'h0F);
    run_cmd(uart_cmd_pkg::OP_READ, 4'd5, 8'h00);
    close_test();

    start_test("illegal opcodes");
    run_cmd(4'd0, 4'd3, 8'h77);
    run_cmd(4'd9, 4'd3, 8'h99);
    run_cmd(uart_cmd_pkg::OP_READ, 4'd3, 8'h00);  // Still 0x10.
    close_test();

    start_test("random sequence");
    for (int i = 0; i < 24; i++) begin
      r = $random(seed);
      run_cmd(uart_cmd_pkg::opcode_t'(r[31:16] % 6), r[11:8], r[7:0]);  // 0 and 5 are illegal.
    end
    close_test();

    repeat (uart_cmd_pkg::BAUD_DIV) @(negedge clk);
    $display("tests %0d, failed %0d, responses %0d, errors %0d",
             test_cnt, fail_cnt, rsp_cnt, err_cnt);
    if (err_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- src/cmd_uart_top.sv
//////////////////////////////////////////////////////////////////////
// Serial command port top level.
// Assembler, executor and response transmitter.
//////////////////////////////////////////////////////////////////////
module cmd_uart_top (
  input  logic clk,    // System clock.
  input  logic rst_n,  // Async active low reset.
  input  logic rx,     // Serial commands in.
  output logic tx      // Serial responses out.
);

  uart_cmd_pkg::cmd_t  cmd;          // Assembled command.
  logic                cmd_rdy;      // Command waiting.
  logic                clr_cmd_rdy;  // Command taken.
  logic                trmt;         // Send request.
  uart_cmd_pkg::byte_t resp;         // Response byte.
  logic                tx_done;      // Response sent.

  cmd_assembler i_cmd_assembler (
    .clk         (clk),
    .rst_n       (rst_n),
    .rx          (rx),
    .clr_cmd_rdy (clr_cmd_rdy),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy)
  );

  cmd_exec i_cmd_exec (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy),
    .tx_done     (tx_done),
    .clr_cmd_rdy (clr_cmd_rdy),
    .trmt        (trmt),
    .resp        (resp)
  );

  uart_tx i_uart_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .trmt    (trmt),
    .tx_data (resp),
    .tx      (tx),
    .tx_done (tx_done)
  );

endmodule

//--- src/cmd_exec.sv
//////////////////////////////////////////////////////////////////////
// Command executor.
// Decode, execute and result stages around a bank of 8-bit
// registers, with the state machine that sends the response.
//////////////////////////////////////////////////////////////////////
module cmd_exec (
  input  logic                clk,          // System clock.
  input  logic                rst_n,        // Async active low reset.
  input  uart_cmd_pkg::cmd_t  cmd,          // Command from the assembler.
  input  logic                cmd_rdy,      // Command waiting.
  input  logic                tx_done,      // Response fully sent.
  output logic                clr_cmd_rdy,  // Command taken.
  output logic                trmt,         // Start sending resp.
  output uart_cmd_pkg::byte_t resp          // Response byte.
);

  typedef enum logic [2:0] {IDLE, DECODE, EXECUTE, RESULT, WAIT_TX} state_t;

  state_t                  state;      // Current state.
  state_t                  nxt_state;  // Next state.
  uart_cmd_pkg::cmd_t      cmd_q;      // Captured command.
  uart_cmd_pkg::opcode_t   op_q;       // Decoded opcode.
  uart_cmd_pkg::reg_addr_t addr_q;     // Decoded register address.
  uart_cmd_pkg::byte_t     data_q;     // Decoded data byte.
  logic                    illegal_q;  // Opcode outside the command set.
  uart_cmd_pkg::byte_t     regs [uart_cmd_pkg::NUM_REGS];  // Register bank.
  uart_cmd_pkg::byte_t     rd_val;     // Addressed register.
  uart_cmd_pkg::byte_t     new_val;    // Value written back.
  uart_cmd_pkg::byte_t     resp_nxt;   // Response for this command.
  logic                    wr_en;      // Opcode updates the bank.

  assign clr_cmd_rdy = (state == IDLE) && cmd_rdy;  // Taken the cycle it is seen.
  assign trmt        = (state == RESULT);           // Single cycle, resp already valid.

  always_ff @(posedge clk) begin
    if (clr_cmd_rdy)
      cmd_q <= cmd;
  end

  //////////////////////////////////////////////////////////////////////
  // Decode stage
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (state == DECODE) begin
      op_q      <= cmd_q[15:12];
      addr_q    <= cmd_q[11:8];
      data_q    <= cmd_q[7:0];
      illegal_q <= !(cmd_q[15:12] inside {uart_cmd_pkg::OP_WRITE, uart_cmd_pkg::OP_READ,
                                          uart_cmd_pkg::OP_ADD, uart_cmd_pkg::OP_XOR});
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Execute stage
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    rd_val   = regs[addr_q];
    new_val  = rd_val;            // READ leaves the register as is.
    wr_en    = 1'b0;
    resp_nxt = rd_val;
    if (illegal_q) begin
      resp_nxt = uart_cmd_pkg::RESP_NAK;
    end else begin
      case (op_q)
        uart_cmd_pkg::OP_WRITE: begin
          new_val  = data_q;
          wr_en    = 1'b1;
          resp_nxt = uart_cmd_pkg::RESP_ACK;
        end
        uart_cmd_pkg::OP_ADD: begin
          new_val  = rd_val + data_q;  // Wraps modulo 256.
          wr_en    = 1'b1;
          resp_nxt = new_val;
        end
        uart_cmd_pkg::OP_XOR: begin
          new_val  = rd_val ^ data_q;
          wr_en    = 1'b1;
          resp_nxt = new_val;
        end
        default: begin
          resp_nxt = rd_val;           // READ.
        end
      endcase
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < uart_cmd_pkg::NUM_REGS; i++)
        regs[i] <= '0;
    end else if ((state == EXECUTE) && wr_en) begin
      regs[addr_q] <= new_val;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result stage
  //////////////////////////////////////////////////////////////////////

  // Loaded as EXECUTE ends so the transmitter sees it with trmt.
  always_ff @(posedge clk) begin
    if (state == EXECUTE)
      resp <= resp_nxt;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    case (state)
      IDLE:    if (cmd_rdy) nxt_state = DECODE;
      DECODE:  nxt_state = EXECUTE;
      EXECUTE: nxt_state = RESULT;
      RESULT:  nxt_state = WAIT_TX;
      WAIT_TX: if (tx_done) nxt_state = IDLE;  // tx_done already low after trmt.
      default: nxt_state = IDLE;
    endcase
  end

endmodule

//--- src/cmd_assembler.sv
//////////////////////////////////////////////////////////////////////
// Command assembler.
// Receives two bytes over UART, high byte first, and presents
// them as one 16-bit command with a held ready flag.
//////////////////////////////////////////////////////////////////////
module cmd_assembler (
  input  logic               clk,          // System clock.
  input  logic               rst_n,        // Async active low reset.
  input  logic               rx,           // Serial input.
  input  logic               clr_cmd_rdy,  // Knocks down cmd_rdy.
  output uart_cmd_pkg::cmd_t cmd,          // Assembled command.
  output logic               cmd_rdy       // Both bytes received.
);

  typedef enum logic {HIGH, LOW} state_t;

  state_t              state;         // Current state.
  state_t              nxt_state;     // Next state.
  uart_cmd_pkg::byte_t rx_data;       // Byte from the receiver.
  logic                rx_rdy;        // Receiver has a byte.
  logic                clr_rx_rdy;    // Acknowledge to the receiver.
  uart_cmd_pkg::byte_t high_byte;     // Held first byte.
  logic                capture_high;  // Store the first byte.
  logic                set_cmd_rdy;   // Second byte arrived.

  uart_rx i_uart_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .clr_rx_rdy (clr_rx_rdy),
    .rx_data    (rx_data),
    .rx_rdy     (rx_rdy)
  );

  always_ff @(posedge clk) begin
    if (capture_high)
      high_byte <= rx_data;
  end

  assign cmd = {high_byte, rx_data};  // Low byte taken live from the receiver.

  //////////////////////////////////////////////////////////////////////
  // Byte sequencing
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= HIGH;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state    = state;
    clr_rx_rdy   = 1'b0;
    capture_high = 1'b0;
    set_cmd_rdy  = 1'b0;
    case (state)
      LOW: begin
        if (rx_rdy) begin
          set_cmd_rdy = 1'b1;  // Command complete.
          clr_rx_rdy  = 1'b1;
          nxt_state   = HIGH;
        end
      end
      default: begin
        if (rx_rdy) begin
          capture_high = 1'b1;
          clr_rx_rdy   = 1'b1;
          nxt_state    = LOW;
        end
      end
    endcase
  end

  // A new high byte invalidates whatever command was waiting.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      cmd_rdy <= 1'b0;
    else if (capture_high || clr_cmd_rdy)
      cmd_rdy <= 1'b0;
    else if (set_cmd_rdy)
      cmd_rdy <= 1'b1;
  end

endmodule

//--- uart/uart_tx.sv
//////////////////////////////////////////////////////////////////////
// UART transmitter, 8N1.
// Load-on-trigger shift register, baud counter and a done flag
// that holds until the next trigger.
//////////////////////////////////////////////////////////////////////
module uart_tx (
  input  logic                clk,      // System clock.
  input  logic                rst_n,    // Async active low reset.
  input  logic                trmt,     // One-cycle send request.
  input  uart_cmd_pkg::byte_t tx_data,  // Byte to send.
  output logic                tx,       // Serial output, idles high.
  output logic                tx_done   // Frame finished.
);

  typedef enum logic {IDLE, SHIFT} state_t;

  state_t                  state;         // Current state.
  state_t                  nxt_state;     // Next state.
  logic [8:0]              tx_shft;       // {data, start bit}.
  uart_cmd_pkg::bit_cnt_t  bit_cnt;       // Bits already sent.
  uart_cmd_pkg::baud_cnt_t baud_cnt;      // Cycles left in this bit.
  logic                    load;          // Accept a new byte.
  logic                    transmitting;  // Frame in progress.
  logic                    shift;         // End of a bit period.
  logic                    set_done;      // End of the stop bit.

  assign transmitting = (state == SHIFT);
  assign shift        = transmitting && (baud_cnt == '0);
  assign set_done     = shift && (bit_cnt == 4'd9);  // Tenth bit is the stop bit.
  assign tx           = tx_shft[0];                  // LSB goes out first.

  // Ones shift in from the top so the stop bit and idle level follow the data.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      tx_shft <= '1;                  // Line idles high.
    else if (load)
      tx_shft <= {tx_data, 1'b0};     // Start bit first.
    else if (shift)
      tx_shft <= {1'b1, tx_shft[8:1]};
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      baud_cnt <= '0;
    else if (load || shift)
      baud_cnt <= uart_cmd_pkg::baud_cnt_t'(uart_cmd_pkg::BAUD_DIV - 1);
    else if (transmitting)
      baud_cnt <= baud_cnt - 1'b1;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (load)
      bit_cnt <= '0;
    else if (shift)
      bit_cnt <= bit_cnt + 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    load      = 1'b0;
    case (state)
      SHIFT: begin
        if (set_done)
          nxt_state = IDLE;
      end
      default: begin
        if (trmt) begin
          load      = 1'b1;  // Requests while busy are ignored.
          nxt_state = SHIFT;
        end
      end
    endcase
  end

  // Done holds from the end of the stop bit until the next trigger.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      tx_done <= 1'b1;
    else if (load)
      tx_done <= 1'b0;
    else if (set_done)
      tx_done <= 1'b1;
  end

endmodule

//--- uart/uart_rx.sv
//////////////////////////////////////////////////////////////////////
// UART receiver, 8N1.
// Start detect on a synchronized input, mid-bit sampling,
// LSB-first shift register and a ready flag held until cleared.
//////////////////////////////////////////////////////////////////////
module uart_rx (
  input  logic                clk,         // System clock.
  input  logic                rst_n,       // Async active low reset.
  input  logic                rx,          // Serial input, idles high.
  input  logic                clr_rx_rdy,  // Knocks down rx_rdy.
  output uart_cmd_pkg::byte_t rx_data,     // Last received byte.
  output logic                rx_rdy       // Byte available.
);

  typedef enum logic {IDLE, SHIFT} state_t;

  state_t                  state;       // Current state.
  state_t                  nxt_state;   // Next state.
  logic                    rx_ff1;      // First sync stage.
  logic                    rx_ff2;      // Second sync stage.
  uart_cmd_pkg::byte_t     rx_shft;     // Data bits as they arrive.
  uart_cmd_pkg::bit_cnt_t  bit_cnt;     // Samples taken in this frame.
  uart_cmd_pkg::baud_cnt_t baud_cnt;    // Counts down to the next sample.
  logic                    start;       // Falling edge of start bit seen.
  logic                    receiving;   // Frame in progress.
  logic                    sample;      // Middle of a bit period.
  logic                    set_rdy;     // Stop bit sampled.

  // Double flop the line since rx is asynchronous to clk.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rx_ff1 <= 1'b1;  // Preset to the idle level.
      rx_ff2 <= 1'b1;
    end else begin
      rx_ff1 <= rx;
      rx_ff2 <= rx_ff1;
    end
  end

  assign receiving = (state == SHIFT);
  assign sample    = receiving && (baud_cnt == '0);
  assign set_rdy   = sample && (bit_cnt == 4'd9);  // Tenth sample is the stop bit.

  //////////////////////////////////////////////////////////////////////
  // Bit timing
  //////////////////////////////////////////////////////////////////////

  // First load lands on mid start bit, less the sync and detect latency.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      baud_cnt <= '0;
    else if (start)
      baud_cnt <= uart_cmd_pkg::baud_cnt_t'(uart_cmd_pkg::BAUD_DIV / 2 - 3);
    else if (sample)
      baud_cnt <= uart_cmd_pkg::baud_cnt_t'(uart_cmd_pkg::BAUD_DIV - 1);
    else if (receiving)
      baud_cnt <= baud_cnt - 1'b1;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (start)
      bit_cnt <= '0;             // Fresh frame.
    else if (sample)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // Only samples 1 to 8 carry data. LSB arrives first.
  always_ff @(posedge clk) begin
    if (sample && (bit_cnt != 4'd0) && (bit_cnt != 4'd9))
      rx_shft <= {rx_ff2, rx_shft[7:1]};
  end

  // Output byte held steady while the next frame shifts in.
  always_ff @(posedge clk) begin
    if (set_rdy)
      rx_data <= rx_shft;
  end

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;  // Hold by default.
    start     = 1'b0;
    case (state)
      SHIFT: begin
        if (set_rdy)
          nxt_state = IDLE;  // Back to idle in the middle of the stop bit.
      end
      default: begin
        if (!rx_ff2) begin
          start     = 1'b1;  // Line went low.
          nxt_state = SHIFT;
        end
      end
    endcase
  end

  // Ready holds until cleared or a new start bit begins.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      rx_rdy <= 1'b0;
    else if (start || clr_rx_rdy)
      rx_rdy <= 1'b0;
    else if (set_rdy)
      rx_rdy <= 1'b1;
  end

endmodule

//--- common/uart_cmd_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared definitions for the serial command port.
// Vector typedefs, opcode and response constants, baud divider
// and register bank size.
//////////////////////////////////////////////////////////////////////
package uart_cmd_pkg;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////
  typedef logic [7:0]  byte_t;      // Serial byte, register value or response.
  typedef logic [15:0] cmd_t;       // {opcode, reg addr, data}.
  typedef logic [3:0]  opcode_t;    // Command opcode in cmd[15:12].
  typedef logic [3:0]  reg_addr_t;  // Register address in cmd[11:8].
  typedef logic [3:0]  bit_cnt_t;   // Counts bit periods in a frame.

  //////////////////////////////////////////////////////////////////////
  // Serial timing
  //////////////////////////////////////////////////////////////////////
  localparam int BAUD_DIV = 434;    // 115200 baud from 50 MHz.

  typedef logic [$clog2(BAUD_DIV)-1:0] baud_cnt_t;  // Cycles within one bit.

  //////////////////////////////////////////////////////////////////////
  // Command set
  //////////////////////////////////////////////////////////////////////
  localparam opcode_t OP_WRITE = 4'd1;  // Store data byte.
  localparam opcode_t OP_READ  = 4'd2;  // Return register value.
  localparam opcode_t OP_ADD   = 4'd3;  // Add data, modulo 256.
  localparam opcode_t OP_XOR   = 4'd4;  // Exclusive-or with data.

  localparam byte_t RESP_ACK = 8'hA5;   // Reply to a write.
  localparam byte_t RESP_NAK = 8'hEE;   // Reply to an illegal opcode.

  localparam int NUM_REGS = 16;         // Size of the register bank.

endpackage
